// ==== verilog/lc3b_pkg.sv ====
`default_nettype none

package lc3b_pkg;

    // ----------------------------------------
    // basic widths
    // ----------------------------------------
    typedef logic [15:0] lc3b_word;   // pc, instructions, data.
    typedef logic [2:0]  lc3b_reg;    // register number.
    typedef logic [3:0]  lc3b_opcode; // bits 15:12.

    // next pc source in mux input order.
    typedef enum logic [2:0] {
        sel_plus2  = 3'd0,
        sel_branch = 3'd1,
        sel_reg    = 3'd2,
        sel_mem    = 3'd3,
        sel_trap   = 3'd4
    } pc_sel_t;

    // ----------------------------------------
    // bundles
    // ----------------------------------------
    typedef struct packed {
        logic br_en;
        logic trap_en;
        logic jmp_jsr_en;
        logic b11;       // jsr vs jsrr.
    } redirect_t;

    typedef struct packed {
        lc3b_word pc_br;
        lc3b_word sr1_data;
        lc3b_word trap_mem;
    } pc_sources_t;

    typedef struct packed {
        logic    load;
        pc_sel_t sel;
    } pc_ctl_t;

    typedef struct packed {
        lc3b_word instruction;
        lc3b_word pc;
        lc3b_reg  src1;
        lc3b_reg  src2;
        lc3b_reg  dest;
    } fetch_out_t;

    localparam lc3b_word reset_pc = 16'h0000;

    // stores read their data register from bits 11:9.
    localparam lc3b_opcode op_stb = 4'b0011;
    localparam lc3b_opcode op_stw = 4'b0111;
    localparam lc3b_opcode op_sti = 4'b1011;

endpackage : lc3b_pkg

`default_nettype wire

// ==== verilog/fetch_redirect.sv ====
`default_nettype none

module fetch_redirect (
    input  lc3b_pkg::redirect_t redirect,
    input  lc3b_pkg::pc_sel_t   pcmux_sel,
    input  logic                stall,
    input  logic                resp_a,
    output lc3b_pkg::pc_ctl_t   pc_ctl,
    output logic                ir_load
);

    logic any_redirect;

    assign any_redirect = redirect.br_en | redirect.trap_en | redirect.jmp_jsr_en;

    // ----------------------------------------
    // pc load
    // ----------------------------------------
    // a redirect wins over the stall level.
    always_comb begin
        if (any_redirect) begin
            pc_ctl.load = 1'b1;
        end else if (stall) begin
            pc_ctl.load = 1'b0;
        end else begin
            pc_ctl.load = resp_a; // advance only on a memory response.
        end
    end

    // ----------------------------------------
    // next pc select
    // ----------------------------------------
    // priority is branch, trap, then jmp/jsr.
    always_comb begin
        if (redirect.br_en) begin
            pc_ctl.sel = lc3b_pkg::sel_branch;
        end else if (redirect.trap_en) begin
            pc_ctl.sel = lc3b_pkg::sel_trap;
        end else if (redirect.jmp_jsr_en) begin
            // jmp and ret have b11 clear, so they take the register.
            if (redirect.b11) begin
                pc_ctl.sel = lc3b_pkg::sel_branch;
            end else begin
                pc_ctl.sel = lc3b_pkg::sel_reg;
            end
        end else begin
            pc_ctl.sel = pcmux_sel; // decode stage choice.
        end
    end

    // the instruction register only takes a word while the pipe moves.
    assign ir_load = resp_a & ~stall;

endmodule : fetch_redirect

`default_nettype wire

// ==== verilog/pc_unit.sv ====
`default_nettype none

module pc_unit (
    input  logic                  clk,
    input  logic                  if_stall_count_reset,
    input  lc3b_pkg::pc_ctl_t     pc_ctl,
    input  lc3b_pkg::pc_sources_t sources,
    input  lc3b_pkg::lc3b_word    rdata_a,
    output lc3b_pkg::lc3b_word    pc
);

    lc3b_pkg::lc3b_word pc_plus2;
    lc3b_pkg::lc3b_word pc_next;

    // ----------------------------------------
    // next pc mux
    // ----------------------------------------
    assign pc_plus2 = pc + 16'd2;

    always_comb begin
        case (pc_ctl.sel)
            lc3b_pkg::sel_plus2: begin
                pc_next = pc_plus2;
            end
            lc3b_pkg::sel_branch: begin
                pc_next = sources.pc_br;
            end
            lc3b_pkg::sel_reg: begin
                pc_next = sources.sr1_data; // jmp, jsrr.
            end
            lc3b_pkg::sel_mem: begin
                pc_next = rdata_a; // trap vector word.
            end
            lc3b_pkg::sel_trap: begin
                pc_next = sources.trap_mem;
            end
            default: begin
                pc_next = '0; // unused mux inputs.
            end
        endcase
    end

    // ----------------------------------------
    // pc register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            pc <= lc3b_pkg::reset_pc;
        end else if (pc_ctl.load) begin
            pc <= pc_next;
        end
    end

endmodule : pc_unit

`default_nettype wire

// ==== verilog/instr_reg.sv ====
`default_nettype none

module instr_reg (
    input  logic                 clk,
    input  logic                 if_stall_count_reset,
    input  logic                 ir_load,
    input  logic                 resp_a,
    input  lc3b_pkg::lc3b_word   rdata_a,
    input  lc3b_pkg::lc3b_word   pc,
    output lc3b_pkg::fetch_out_t fetched,
    output lc3b_pkg::lc3b_word   if_stall_count
);

    lc3b_pkg::lc3b_word   ir_q;
    lc3b_pkg::lc3b_word   ir_pc_q;
    lc3b_pkg::lc3b_opcode opcode;
    logic                 is_store;

    // ----------------------------------------
    // instruction register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            ir_q    <= '0;
            ir_pc_q <= '0;
        end else if (ir_load) begin
            ir_q    <= rdata_a;
            ir_pc_q <= pc; // pc the word was fetched from.
        end
    end

    // field decode on the held word.
    assign opcode = ir_q[15:12];

    always_comb begin
        is_store = (opcode == lc3b_pkg::op_stb) ||
                   (opcode == lc3b_pkg::op_stw) ||
                   (opcode == lc3b_pkg::op_sti);
    end

    always_comb begin
        fetched.instruction = ir_q;
        fetched.pc          = ir_pc_q;
        fetched.dest        = ir_q[11:9];
        fetched.src1        = ir_q[8:6];
        // stores name their data register where dest would be.
        if (is_store) begin
            fetched.src2 = ir_q[11:9];
        end else begin
            fetched.src2 = ir_q[2:0];
        end
    end

    // ----------------------------------------
    // fetch wait counter
    // ----------------------------------------
    // counts cycles with no memory response, wraps at 16 bits.
    always_ff @(posedge clk) begin
        if (if_stall_count_reset) begin
            if_stall_count <= '0;
        end else if (!resp_a) begin
            if_stall_count <= if_stall_count + 16'd1;
        end
    end

endmodule : instr_reg

`default_nettype wire

// ==== verilog/if_stage.sv ====
`default_nettype none

module if_stage (
    input  logic                  clk,
    input  logic                  if_stall_count_reset,

    // memory side
    input  logic                  resp_a,
    input  lc3b_pkg::lc3b_word    rdata_a,
    output lc3b_pkg::lc3b_word    address_a,

    // pipeline control
    input  lc3b_pkg::redirect_t   redirect,
    input  lc3b_pkg::pc_sources_t sources,
    input  lc3b_pkg::pc_sel_t     pcmux_sel,
    input  logic                  stall,

    // results
    output lc3b_pkg::fetch_out_t  fetched,
    output lc3b_pkg::lc3b_word    if_stall_count
);

    lc3b_pkg::pc_ctl_t pc_ctl;
    logic              ir_load;

    fetch_redirect fetch_redirect_i (
        .redirect  (redirect),
        .pcmux_sel (pcmux_sel),
        .stall     (stall),
        .resp_a    (resp_a),
        .pc_ctl    (pc_ctl),
        .ir_load   (ir_load)
    );

    // the pc drives the memory address directly.
    pc_unit pc_unit_i (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .pc_ctl               (pc_ctl),
        .sources              (sources),
        .rdata_a              (rdata_a),
        .pc                   (address_a)
    );

    instr_reg instr_reg_i (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .ir_load              (ir_load),
        .resp_a               (resp_a),
        .rdata_a              (rdata_a),
        .pc                   (address_a),
        .fetched              (fetched),
        .if_stall_count       (if_stall_count)
    );

endmodule : if_stage

`default_nettype wire

// ==== bench/clock_gen.sv ====
`default_nettype none

module clock_gen (
    output logic clk
);

    localparam int half_period = 4; // period 8.

    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule : clock_gen

`default_nettype wire

// ==== bench/if_stage_tb.sv ====
`default_nettype none

module if_stage_tb;

    typedef struct packed {
        logic                  rst;
        logic                  resp;
        lc3b_pkg::lc3b_word    rdata;
        logic                  stall;
        lc3b_pkg::redirect_t   redirect;
        lc3b_pkg::pc_sources_t sources;
        lc3b_pkg::pc_sel_t     sel;
        lc3b_pkg::lc3b_word    exp_address;
        lc3b_pkg::fetch_out_t  exp_fetched;
        lc3b_pkg::lc3b_word    exp_count;
    } row_t;

    logic                  clk;
    logic                  if_stall_count_reset;
    logic                  resp_a;
    lc3b_pkg::lc3b_word    rdata_a;
    lc3b_pkg::redirect_t   redirect;
    lc3b_pkg::pc_sources_t sources;
    lc3b_pkg::pc_sel_t     pcmux_sel;
    logic                  stall;
    lc3b_pkg::lc3b_word    address_a;
    lc3b_pkg::fetch_out_t  fetched;
    lc3b_pkg::lc3b_word    if_stall_count;

    row_t  rows[$];
    string names[$];

    // reference model state.
    lc3b_pkg::lc3b_word m_pc;
    lc3b_pkg::lc3b_word m_ir;
    lc3b_pkg::lc3b_word m_ir_pc;
    lc3b_pkg::lc3b_word m_count;
    logic [31:0]        lcg_state;

    clock_gen clock_gen_i (
        .clk (clk)
    );

    if_stage if_stage_i (
        .clk                  (clk),
        .if_stall_count_reset (if_stall_count_reset),
        .resp_a               (resp_a),
        .rdata_a              (rdata_a),
        .address_a            (address_a),
        .redirect             (redirect),
        .sources              (sources),
        .pcmux_sel            (pcmux_sel),
        .stall                (stall),
        .fetched              (fetched),
        .if_stall_count       (if_stall_count)
    );

    task automatic fail_run(input string reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", what, expected, actual);
            fail_run("output mismatch");
        end
    endtask

    function automatic lc3b_pkg::lc3b_word lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // fields as the decode stage expects them.
    function automatic lc3b_pkg::fetch_out_t expect_fetch(input lc3b_pkg::lc3b_word ir,
                                                          input lc3b_pkg::lc3b_word pc);
        lc3b_pkg::fetch_out_t f;
        logic [3:0]           op;
        op            = ir[15:12];
        f.instruction = ir;
        f.pc          = pc;
        f.dest        = ir[11:9];
        f.src1        = ir[8:6];
        if (op == 4'h3 || op == 4'h7 || op == 4'hb) begin
            f.src2 = ir[11:9]; // stb, stw, sti.
        end else begin
            f.src2 = ir[2:0];
        end
        return f;
    endfunction

    // steps the model by one cycle and stores the row with its expected outputs.
    task automatic add_row(input string name, input logic rst, input logic resp,
                           input lc3b_pkg::lc3b_word rdata, input logic stall_in,
                           input lc3b_pkg::redirect_t rd, input lc3b_pkg::pc_sources_t src,
                           input lc3b_pkg::pc_sel_t sel);
        row_t               r;
        lc3b_pkg::pc_sel_t  s;
        lc3b_pkg::lc3b_word next_pc;
        logic               load;
        if (rst) begin
            m_pc    = '0;
            m_ir    = '0;
            m_ir_pc = '0;
            m_count = '0;
        end else begin
            if (rd.br_en) begin
                s = lc3b_pkg::sel_branch;
            end else if (rd.trap_en) begin
                s = lc3b_pkg::sel_trap;
            end else if (rd.jmp_jsr_en) begin
                s = rd.b11 ? lc3b_pkg::sel_branch : lc3b_pkg::sel_reg;
            end else begin
                s = sel;
            end
            load = rd.br_en || rd.trap_en || rd.jmp_jsr_en || (!stall_in && resp);
            case (s)
                lc3b_pkg::sel_plus2:  next_pc = m_pc + 16'd2;
                lc3b_pkg::sel_branch: next_pc = src.pc_br;
                lc3b_pkg::sel_reg:    next_pc = src.sr1_data;
                lc3b_pkg::sel_mem:    next_pc = rdata;
                lc3b_pkg::sel_trap:   next_pc = src.trap_mem;
                default:              next_pc = '0;
            endcase
            if (resp && !stall_in) begin
                m_ir    = rdata;
                m_ir_pc = m_pc; // old pc, before the update.
            end
            if (!resp) begin
                m_count = m_count + 16'd1;
            end
            if (load) begin
                m_pc = next_pc;
            end
        end
        r.rst         = rst;
        r.resp        = resp;
        r.rdata       = rdata;
        r.stall       = stall_in;
        r.redirect    = rd;
        r.sources     = src;
        r.sel         = sel;
        r.exp_address = m_pc;
        r.exp_fetched = expect_fetch(m_ir, m_ir_pc);
        r.exp_count   = m_count;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        lc3b_pkg::pc_sources_t src;
        lc3b_pkg::pc_sources_t src_far;
        lc3b_pkg::lc3b_word    words[6];
        int                    i;
        lcg_state = 32'd76177;
        m_pc      = '0;
        m_ir      = '0;
        m_ir_pc   = '0;
        m_count   = '0;
        src       = {16'h1230, 16'h2468, 16'h0400}; // pc_br, sr1_data, trap_mem.
        src_far   = {16'h3456, 16'h2468, 16'h0400}; // branch target away from the pc.
        for (i = 0; i < 8; i++) begin
            add_row($sformatf("seq_%0d", i), 1'b0, 1'b1, lcg_next(), 1'b0, '0, src,
                    lc3b_pkg::sel_plus2);
        end
        add_row("stall_hold", 1'b0, 1'b1, 16'h1111, 1'b1, '0, src, lc3b_pkg::sel_plus2);
        add_row("stall_hold_2", 1'b0, 1'b1, 16'h2222, 1'b1, '0, src, lc3b_pkg::sel_plus2);
        add_row("wait_mem", 1'b0, 1'b0, 16'h3333, 1'b0, '0, src, lc3b_pkg::sel_plus2);
        add_row("wait_mem_stall", 1'b0, 1'b0, 16'h4444, 1'b1, '0, src, lc3b_pkg::sel_plus2);
        // ----------------------------------------
        // redirects (bits are br trap jmp b11)
        // ----------------------------------------
        add_row("br_over_all", 1'b0, 1'b1, 16'h5555, 1'b0, 4'b1111, src, lc3b_pkg::sel_plus2);
        add_row("trap_over_jmp", 1'b0, 1'b1, 16'h6666, 1'b0, 4'b0111, src, lc3b_pkg::sel_plus2);
        add_row("jmp_reg", 1'b0, 1'b1, 16'hc180, 1'b0, 4'b0010, src, lc3b_pkg::sel_plus2);
        add_row("jsr_pc_br", 1'b0, 1'b1, 16'h4800, 1'b0, 4'b0011, src, lc3b_pkg::sel_plus2);
        add_row("br_in_stall", 1'b0, 1'b0, 16'h7777, 1'b1, 4'b1000, src_far,
                lc3b_pkg::sel_plus2);
        add_row("sel_mem", 1'b0, 1'b1, 16'h0a0c, 1'b0, '0, src, lc3b_pkg::sel_mem);
        add_row("sel_reg", 1'b0, 1'b1, 16'h1000, 1'b0, '0, src, lc3b_pkg::sel_reg);
        // stores first, then non stores with the same low fields.
        words = '{16'h3a86, 16'h7c47, 16'hb6d2, 16'h1a86, 16'h6c47, 16'hf6d2};
        for (i = 0; i < 6; i++) begin
            add_row($sformatf("decode_%0d", i), 1'b0, 1'b1, words[i], 1'b0, '0, src,
                    lc3b_pkg::sel_plus2);
        end
        add_row("mid_reset", 1'b1, 1'b1, 16'h0000, 1'b0, '0, src, lc3b_pkg::sel_plus2);
        add_row("count_1", 1'b0, 1'b0, 16'h0000, 1'b0, '0, src, lc3b_pkg::sel_plus2);
        add_row("count_2", 1'b0, 1'b0, 16'h0000, 1'b0, '0, src, lc3b_pkg::sel_plus2);
        add_row("resume", 1'b0, 1'b1, 16'h5a5a, 1'b0, '0, src, lc3b_pkg::sel_plus2);
    endtask

    task automatic apply_row(input row_t r);
        if_stall_count_reset <= r.rst;
        resp_a               <= r.resp;
        rdata_a              <= r.rdata;
        stall                <= r.stall;
        redirect             <= r.redirect;
        sources              <= r.sources;
        pcmux_sel            <= r.sel;
    endtask

    initial begin
        int i;
        int waited;
        if_stall_count_reset = 1'b1;
        resp_a               = 1'b0;
        rdata_a              = '0;
        stall                = 1'b0;
        redirect             = '0;
        sources              = '0;
        pcmux_sel            = lc3b_pkg::sel_plus2;
        build_table();
        repeat (16) @(posedge clk);
        waited = 0;
        while (address_a !== '0 || fetched !== '0 || if_stall_count !== '0) begin
            if (waited == 50) begin
                fail_run("fetch stage did not clear within 50 cycles of reset");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
        apply_row(rows[0]); // also releases reset.
        for (i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            if (i + 1 < rows.size()) begin
                apply_row(rows[i + 1]);
            end
            @(negedge clk); // outputs settled after the edge.
            check({names[i], " address_a"}, 64'(rows[i].exp_address), 64'(address_a));
            check({names[i], " fetched"}, 64'(rows[i].exp_fetched), 64'(fetched));
            check({names[i], " if_stall_count"}, 64'(rows[i].exp_count),
                  64'(if_stall_count));
        end
        $display("Test passed");
        $finish;
    end

endmodule : if_stage_tb

`default_nettype wire

// ==== sources.f ====
verilog/lc3b_pkg.sv
verilog/fetch_redirect.sv
verilog/pc_unit.sv
verilog/instr_reg.sv
verilog/if_stage.sv
bench/clock_gen.sv
bench/if_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module if_stage_tb -o if_stage_sim

# a failing run still leaves its log for the search below
./obj_dir/if_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
else
    exit 1
fi
